// ==== src/acq_pkg.sv ====
package acq_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  // adc sample width
  localparam int unsigned sample_w = 16;
  // decimation factor width
  localparam int unsigned dec_w    = 8;
  // burst length width
  localparam int unsigned burst_w  = 8;
  // beat counters and checksums
  localparam int unsigned count_w  = 32;

  //////////////////////////////////////////////////
  // shared types
  //////////////////////////////////////////////////

  // one adc word, strobe plus signed sample
  typedef struct packed {
    logic                       valid;
    logic signed [sample_w-1:0] data;
  } adc_sample_t;

  // per channel settings, zero factor or length means one
  typedef struct packed {
    logic [dec_w-1:0]           decimation;
    logic signed [sample_w-1:0] trig_level;
    logic [burst_w-1:0]         burst_len;
  } chan_cfg_t;

  // stream beat, no ready
  typedef struct packed {
    logic                tvalid;
    logic                tlast;
    logic [sample_w-1:0] tdata;
  } stream_beat_t;

  // per channel totals seen by the sink
  typedef struct packed {
    logic [count_w-1:0] beats;
    logic [count_w-1:0] checksum;
    logic               irq;
  } chan_stat_t;

  // both channels plus done flag
  typedef struct packed {
    chan_stat_t chan0;
    chan_stat_t chan1;
    logic       capture_done;
  } acq_status_t;

endpackage

// ==== src/osc_channel.sv ====
module osc_channel
  import acq_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  adc_sample_t  adc,
  input  chan_cfg_t    cfg,
  input  logic         arm,
  output stream_beat_t beat,
  output logic         irq
);

  typedef enum logic [1:0] {
    st_idle,
    st_armed,
    st_burst
  } state_t;

  state_t                     state_q;
  chan_cfg_t                  cfg_q;
  logic [dec_w-1:0]           dec_cnt_q;
  logic [dec_w-1:0]           dec_eff;
  logic [burst_w-1:0]         beat_cnt_q;
  logic [burst_w-1:0]         len_eff;
  logic [burst_w-1:0]         beat_num;
  logic signed [sample_w-1:0] sample;
  logic signed [sample_w-1:0] level;
  logic signed [sample_w-1:0] prev_q;
  logic                       prev_vld_q;
  logic                       arm_ok;
  logic                       dec_hit;
  logic                       track;
  logic                       crossing;
  logic                       fire;
  logic                       emit;
  logic                       last;
  logic                       beat_vld_q;
  logic                       beat_last_q;
  logic                       irq_q;
  logic [sample_w-1:0]        beat_data_q;

  //////////////////////////////////////////////////
  // decimation and trigger decode
  //////////////////////////////////////////////////

  // zero in the settings behaves as one
  assign dec_eff = (cfg_q.decimation == '0) ? dec_w'(1) : cfg_q.decimation;
  assign len_eff = (cfg_q.burst_len == '0) ? burst_w'(1) : cfg_q.burst_len;

  assign sample = adc.data;
  assign level  = cfg_q.trig_level;

  // arm only accepted outside a burst
  assign arm_ok  = arm && (state_q != st_burst);
  // strobe that closes a decimation period
  assign dec_hit = adc.valid && (dec_cnt_q == dec_eff - 1'b1);

  // armed and looking at a decimated sample
  // an accepted arm restarts everything, so that strobe is dropped
  assign track    = (state_q == st_armed) && dec_hit && !arm_ok;
  // rising crossing, needs a previous sample below the level
  assign crossing = prev_vld_q && (prev_q < level) && (sample >= level);
  assign fire     = track && crossing;

  // triggering sample is beat 1, then every decimated sample in burst
  assign emit     = fire || ((state_q == st_burst) && dec_hit);
  assign beat_num = (state_q == st_burst) ? beat_cnt_q + 1'b1 : burst_w'(1);
  assign last     = (beat_num == len_eff);

  //////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= st_idle;
      cfg_q       <= '0;
      dec_cnt_q   <= '0;
      prev_vld_q  <= 1'b0;
      beat_cnt_q  <= '0;
      beat_vld_q  <= 1'b0;
      beat_last_q <= 1'b0;
      irq_q       <= 1'b0;
    end else begin
      // outgoing beat one cycle after its adc strobe
      beat_vld_q  <= emit;
      beat_last_q <= emit && last;
      irq_q       <= emit && last;

      if (arm_ok) begin
        cfg_q      <= cfg;
        state_q    <= st_armed;
        dec_cnt_q  <= '0;
        prev_vld_q <= 1'b0;
      end else begin
        if (adc.valid) begin
          dec_cnt_q <= dec_hit ? '0 : dec_cnt_q + 1'b1;
        end
        if (track) begin
          prev_vld_q <= 1'b1;
        end
        // burst_len of one goes straight back to idle
        if (emit) begin
          beat_cnt_q <= beat_num;
          state_q    <= last ? st_idle : st_burst;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // sample payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (track) begin
      prev_q <= sample;
    end
    if (emit) begin
      beat_data_q <= sample;
    end
  end

  assign beat.tvalid = beat_vld_q;
  assign beat.tlast  = beat_last_q;
  assign beat.tdata  = beat_data_q;
  assign irq         = irq_q;

endmodule

// ==== src/ps_stream_sink.sv ====
module ps_stream_sink
  import acq_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  stream_beat_t beat0,
  input  stream_beat_t beat1,
  input  logic         irq0,
  input  logic         irq1,
  input  logic         stat_clear,
  output acq_status_t  status
);

  // channel count of the subsystem
  localparam int unsigned n_chan = 2;

  stream_beat_t beat_in [n_chan];
  logic         irq_in  [n_chan];
  chan_stat_t   stat_q  [n_chan];

  //////////////////////////////////////////////////
  // input gather
  //////////////////////////////////////////////////

  // sink is always ready, every tvalid is taken
  assign beat_in[0] = beat0;
  assign beat_in[1] = beat1;
  assign irq_in[0]  = irq0;
  assign irq_in[1]  = irq1;

  //////////////////////////////////////////////////
  // per channel accumulators
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < n_chan; ch++) begin : gen_acc

    logic [count_w-1:0] data_ext;
    logic [count_w-1:0] beats_base;
    logic [count_w-1:0] sum_base;

    // checksum adds tdata as unsigned
    assign data_ext = count_w'(beat_in[ch].tdata);

    // clear first, a beat in the same cycle lands on top
    assign beats_base = stat_clear ? '0 : stat_q[ch].beats;
    assign sum_base   = stat_clear ? '0 : stat_q[ch].checksum;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        stat_q[ch] <= '0;
      end else begin
        if (beat_in[ch].tvalid) begin
          stat_q[ch].beats    <= beats_base + 1'b1;
          stat_q[ch].checksum <= sum_base + data_ext;
        end else begin
          stat_q[ch].beats    <= beats_base;
          stat_q[ch].checksum <= sum_base;
        end

        // sticky irq, a pulse beats a clear
        if (irq_in[ch]) begin
          stat_q[ch].irq <= 1'b1;
        end else if (stat_clear) begin
          stat_q[ch].irq <= 1'b0;
        end
      end
    end

  end

  //////////////////////////////////////////////////
  // combined status
  //////////////////////////////////////////////////

  assign status.chan0 = stat_q[0];
  assign status.chan1 = stat_q[1];

  // done while both channels hold their interrupt
  assign status.capture_done = stat_q[0].irq & stat_q[1].irq;

endmodule

// ==== src/acq_top.sv ====
module acq_top
  import acq_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  adc_sample_t adc0,
  input  adc_sample_t adc1,
  input  chan_cfg_t   cfg0,
  input  chan_cfg_t   cfg1,
  input  logic [1:0]  arm,
  input  logic        stat_clear,
  output acq_status_t status
);

  // streams and interrupts between channels and sink
  stream_beat_t beat0;
  stream_beat_t beat1;
  logic         irq0;
  logic         irq1;

  //////////////////////////////////////////////////
  // channels
  //////////////////////////////////////////////////

  osc_channel chan0_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .adc    (adc0),
    .cfg    (cfg0),
    .arm    (arm[0]),
    .beat   (beat0),
    .irq    (irq0)
  );

  osc_channel chan1_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .adc    (adc1),
    .cfg    (cfg1),
    .arm    (arm[1]),
    .beat   (beat1),
    .irq    (irq1)
  );

  //////////////////////////////////////////////////
  // stream sink
  //////////////////////////////////////////////////

  // status trails the closing adc strobe by two cycles
  ps_stream_sink sink_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .beat0      (beat0),
    .beat1      (beat1),
    .irq0       (irq0),
    .irq1       (irq1),
    .stat_clear (stat_clear),
    .status     (status)
  );

endmodule

// ==== tests/clk_gen.sv ====
module clk_gen (
  output logic clk
);

  // half of the 8 unit period
  localparam int half_period = 4;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

// ==== tests/acq_asserts.sv ====
module acq_asserts
  import acq_pkg::*;
(
  input logic         clk,
  input logic         arst_n,
  input logic         adc_valid,
  input stream_beat_t beat,
  input logic         irq
);

  // failed assertions, read by the testbench
  int unsigned fail_cnt = 0;

  // tlast only on a valid beat
  tlast_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
    beat.tlast |-> beat.tvalid)
  else begin
    fail_cnt++;
    $error("tlast seen without tvalid");
  end

  // irq pulse marks exactly the closing beat
  irq_on_last: assert property (@(posedge clk) disable iff (!arst_n)
    irq == (beat.tvalid && beat.tlast))
  else begin
    fail_cnt++;
    $error("irq does not match tvalid and tlast");
  end

  // every beat trails an adc strobe by one cycle
  beat_after_strobe: assert property (@(posedge clk) disable iff (!arst_n)
    beat.tvalid |-> $past(adc_valid))
  else begin
    fail_cnt++;
    $error("beat without an adc strobe one cycle before");
  end

endmodule

bind osc_channel acq_asserts asserts_inst (
  .clk       (clk),
  .arst_n    (arst_n),
  .adc_valid (adc.valid),
  .beat      (beat),
  .irq       (irq)
);

// ==== tests/acq_tb.sv ====
module acq_tb
  import acq_pkg::*;
();

  //////////////////////////////////////////////////
  // run length and watchdog
  //////////////////////////////////////////////////

  localparam int reset_cycles = 16;
  localparam int ramp_len     = 48;
  localparam int dual_len     = 64;
  localparam int flat_len     = 40;
  localparam int rand_len     = 160;
  localparam int rand_rounds  = 3;
  localparam int stim_len     = reset_cycles + ramp_len + dual_len + flat_len
                              + 2 * ramp_len + rand_rounds * rand_len;
  localparam int cycle_limit  = 2 * stim_len + 100;
  // model channel states
  localparam int m_idle  = 0;
  localparam int m_armed = 1;
  localparam int m_burst = 2;

  logic        clk;
  logic        arst_n;
  adc_sample_t adc0;
  adc_sample_t adc1;
  chan_cfg_t   cfg0;
  chan_cfg_t   cfg1;
  logic [1:0]  arm;
  logic        stat_clear;
  acq_status_t status;

  int seed      = 42571;
  int cycle_cnt = 0;
  int assert_fails;

  // reference model with one entry per channel
  int                         m_state [2];
  int                         m_cnt   [2];
  int                         m_beat  [2];
  logic signed [sample_w-1:0] m_prev  [2];
  bit                         m_prev_vld [2];
  chan_cfg_t                  m_cfg   [2];
  chan_stat_t                 exp_stat [2];

  clk_gen clk_gen_inst (.clk(clk));

  acq_top acq_top_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .adc0       (adc0),
    .adc1       (adc1),
    .cfg0       (cfg0),
    .cfg1       (cfg1),
    .arm        (arm),
    .stat_clear (stat_clear),
    .status     (status)
  );

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first failure");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, no result within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // arm ignored while a burst runs
  task automatic model_arm(input int ch, input chan_cfg_t c);
    if (m_state[ch] != m_burst) begin
      m_cfg[ch]      = c;
      m_state[ch]    = m_armed;
      m_cnt[ch]      = 0;
      m_prev_vld[ch] = 1'b0;
    end
  endtask

  task automatic model_sample(input int ch, input adc_sample_t s);
    int                         dec;
    int                         len;
    logic signed [sample_w-1:0] lvl;
    logic signed [sample_w-1:0] d;
    logic [sample_w-1:0]        du;
    dec = (m_cfg[ch].decimation == 0) ? 1 : int'(m_cfg[ch].decimation);
    len = (m_cfg[ch].burst_len == 0) ? 1 : int'(m_cfg[ch].burst_len);
    lvl = m_cfg[ch].trig_level;
    d   = s.data;
    du  = s.data;
    if (!s.valid) return;
    // keep every dec-th strobe
    m_cnt[ch]++;
    if (m_cnt[ch] < dec) return;
    m_cnt[ch] = 0;
    // first sample after arm only primes the crossing
    if (m_state[ch] == m_armed) begin
      if (m_prev_vld[ch] && m_prev[ch] < lvl && d >= lvl) begin
        m_state[ch] = m_burst;
        m_beat[ch]  = 0;
      end
      m_prev[ch]     = d;
      m_prev_vld[ch] = 1'b1;
    end
    if (m_state[ch] == m_burst) begin
      m_beat[ch]++;
      exp_stat[ch].beats    = exp_stat[ch].beats + 1;
      exp_stat[ch].checksum = exp_stat[ch].checksum + count_w'(du);
      if (m_beat[ch] == len) begin
        exp_stat[ch].irq = 1'b1;
        m_state[ch]      = m_idle;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // drive and compare
  //////////////////////////////////////////////////

  function automatic adc_sample_t mk_sample(input logic v, input int val);
    adc_sample_t s;
    s.valid = v;
    s.data  = sample_w'(val);
    return s;
  endfunction

  // one cycle of samples driven on the falling edge
  task automatic drive_samples(input adc_sample_t s0, input adc_sample_t s1, input logic clr);
    @(negedge clk);
    adc0       = s0;
    adc1       = s1;
    arm        = 2'b00;
    stat_clear = clr;
    if (clr) begin
      exp_stat[0] = '0;
      exp_stat[1] = '0;
    end
    model_sample(0, s0);
    model_sample(1, s1);
  endtask

  task automatic arm_channels(input logic [1:0] mask, input chan_cfg_t c0, input chan_cfg_t c1);
    @(negedge clk);
    adc0       = '0;
    adc1       = '0;
    cfg0       = c0;
    cfg1       = c1;
    arm        = mask;
    stat_clear = 1'b0;
    if (mask[0]) model_arm(0, c0);
    if (mask[1]) model_arm(1, c1);
  endtask

  task automatic compare_stat(input string name, input string tag,
                              input chan_stat_t got, input chan_stat_t want);
    if (got.beats !== want.beats) begin
      $display("ERROR %s.beats got 0x%h expected 0x%h (%s)", name, got.beats, want.beats, tag);
      abort_run();
    end
    if (got.checksum !== want.checksum) begin
      $display("ERROR %s.checksum got 0x%h expected 0x%h (%s)", name, got.checksum,
               want.checksum, tag);
      abort_run();
    end
    if (got.irq !== want.irq) begin
      $display("ERROR %s.irq got 0x%h expected 0x%h (%s)", name, got.irq, want.irq, tag);
      abort_run();
    end
  endtask

  task automatic compare_status(input string tag, input acq_status_t got, input acq_status_t want);
    compare_stat("status.chan0", tag, got.chan0, want.chan0);
    compare_stat("status.chan1", tag, got.chan1, want.chan1);
    if (got.capture_done !== want.capture_done) begin
      $display("ERROR status.capture_done got 0x%h expected 0x%h (%s)", got.capture_done,
               want.capture_done, tag);
      abort_run();
    end
  endtask

  // quiet inputs and wait for expected irq bits before comparing
  task automatic settle_and_check(input string tag);
    acq_status_t want;
    drive_samples('0, '0, 1'b0);
    repeat (3) @(negedge clk);
    while ((exp_stat[0].irq && !status.chan0.irq) || (exp_stat[1].irq && !status.chan1.irq))
      @(negedge clk);
    want.chan0        = exp_stat[0];
    want.chan1        = exp_stat[1];
    want.capture_done = exp_stat[0].irq & exp_stat[1].irq;
    compare_status(tag, status, want);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  // channel 0 alone on a ramp through level 100
  task automatic test_single_ramp();
    chan_cfg_t c0;
    c0 = '{decimation: 8'd3, trig_level: 16'sd100, burst_len: 8'd5};
    arm_channels(2'b01, c0, '0);
    for (int i = 0; i < ramp_len; i++)
      drive_samples(mk_sample(1'b1, -200 + 10 * i), '0, 1'b0);
    settle_and_check("single ramp");
  endtask

  // sawtooth on ch0 and sparse ramp on ch1 in the same cycles
  task automatic test_dual_overlap();
    chan_cfg_t c0;
    chan_cfg_t c1;
    c0 = '{decimation: 8'd2, trig_level: 16'sd0, burst_len: 8'd6};
    c1 = '{decimation: 8'd1, trig_level: -16'sd50, burst_len: 8'd4};
    // start from zero so both irq bits come from this burst
    drive_samples('0, '0, 1'b1);
    arm_channels(2'b11, c0, c1);
    for (int i = 0; i < dual_len; i++)
      drive_samples(mk_sample(1'b1, (13 * i) % 200 - 100), mk_sample(i % 2 == 1, 5 * i - 120),
                    1'b0);
    settle_and_check("dual overlap");
  endtask

  // both signals stay above level
  task automatic test_no_trigger();
    chan_cfg_t c;
    c = '{decimation: 8'd2, trig_level: 16'sd0, burst_len: 8'd3};
    drive_samples('0, '0, 1'b1);
    arm_channels(2'b11, c, c);
    for (int i = 0; i < flat_len; i++)
      drive_samples(mk_sample(1'b1, 500 + 7 * i), mk_sample(1'b1, 1000 - i), 1'b0);
    settle_and_check("no trigger");
  endtask

  // bursts on both channels before the clear, then channel 0 rearmed
  task automatic test_clear_rearm();
    chan_cfg_t c0;
    chan_cfg_t c1;
    c0 = '{decimation: 8'd2, trig_level: -16'sd20, burst_len: 8'd3};
    c1 = '{decimation: 8'd1, trig_level: 16'sd5, burst_len: 8'd2};
    arm_channels(2'b11, c0, c1);
    for (int i = 0; i < ramp_len; i++)
      drive_samples(mk_sample(1'b1, -100 + 5 * i), mk_sample(1'b1, -30 + 2 * i), 1'b0);
    settle_and_check("before clear");
    drive_samples('0, '0, 1'b1);
    settle_and_check("after clear");
    // second burst with fresh totals
    c0 = '{decimation: 8'd1, trig_level: 16'sd30, burst_len: 8'd7};
    arm_channels(2'b01, c0, '0);
    for (int i = 0; i < ramp_len; i++)
      drive_samples(mk_sample(1'b1, -60 + 4 * i), '0, 1'b0);
    settle_and_check("after rearm");
  endtask

  function automatic chan_cfg_t random_cfg();
    chan_cfg_t c;
    c.decimation = dec_w'(($random(seed) & 7) + 1);
    c.burst_len  = burst_w'(($random(seed) & 7) + 1);
    c.trig_level = sample_w'($random(seed) % 41);
    return c;
  endfunction

  function automatic adc_sample_t random_sample();
    return mk_sample(($random(seed) & 3) != 0, $random(seed) % 101);
  endfunction

  task automatic test_random();
    for (int r = 0; r < rand_rounds; r++) begin
      drive_samples('0, '0, 1'b1);
      arm_channels(2'b11, random_cfg(), random_cfg());
      for (int i = 0; i < rand_len; i++)
        drive_samples(random_sample(), random_sample(), 1'b0);
      settle_and_check("random");
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    adc0       = '0;
    adc1       = '0;
    cfg0       = '0;
    cfg1       = '0;
    arm        = 2'b00;
    stat_clear = 1'b0;
    for (int ch = 0; ch < 2; ch++) begin
      m_state[ch]    = m_idle;
      m_cnt[ch]      = 0;
      m_beat[ch]     = 0;
      m_prev[ch]     = '0;
      m_prev_vld[ch] = 1'b0;
      m_cfg[ch]      = '0;
      exp_stat[ch]   = '0;
    end
    repeat (reset_cycles) @(negedge clk);
    arst_n = 1'b1;
    settle_and_check("after reset");
    test_single_ramp();
    test_dual_overlap();
    test_no_trigger();
    test_clear_rearm();
    test_random();
    assert_fails = acq_top_inst.chan0_inst.asserts_inst.fail_cnt
                 + acq_top_inst.chan1_inst.asserts_inst.fail_cnt;
    if (assert_fails == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("%0d concurrent assertion failures in the channels", assert_fails);
      abort_run();
    end
  end

endmodule

// ==== build.f ====
src/acq_pkg.sv
src/osc_channel.sv
src/ps_stream_sink.sv
src/acq_top.sv
tests/clk_gen.sv
tests/acq_asserts.sv
tests/acq_tb.sv

// ==== Bender.yml ====
package:
  name: acq

sources:
  - files:
      - src/acq_pkg.sv
      - src/osc_channel.sv
      - src/ps_stream_sink.sv
      - src/acq_top.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/acq_asserts.sv
      - tests/acq_tb.sv
